// File: tb/exec_tests.mem
// columns in hex: op rs1_data rs2_data imm pc rd expected_result expected_target
// op codes follow riscv_isa_pkg::exec_op_e, 3f is an unknown code
01 00000005 00000007 00000000 00001000 01 0000000c 00000000
02 00000003 00000005 00000000 00001004 02 fffffffe 00000000
03 f0f0f0f0 0ff00ff0 00000000 00001008 03 ff00ff00 00000000
04 f0f0f0f0 0ff00ff0 00000000 0000100c 04 fff0fff0 00000000
05 f0f0f0f0 0ff00ff0 00000000 00001010 05 00f000f0 00000000
0b 00000010 12345678 fffffff0 00001014 06 00000000 00000000
0c 0000ffff 00000000 00000f0f 00001018 07 0000f0f0 00000000
0d 12340000 00000000 00005678 0000101c 08 12345678 00000000
0e abcdef01 00000000 0000ff00 00001020 09 0000ef00 00000000
06 00000001 00000024 00000000 00001024 0a 00000010 00000000
07 80000000 00000021 00000000 00001028 0b 40000000 00000000
08 80000000 00000004 00000000 0000102c 0c f8000000 00000000
11 f0000000 00000000 0000003c 00001030 0d ffffffff 00000000
0f 0000000f 00000000 0000001f 00001034 0e 80000000 00000000
09 ffffffff 00000001 00000000 00001038 0f 00000001 00000000
0a ffffffff 00000001 00000000 0000103c 10 00000000 00000000
12 ffffffff 80000000 00000001 00001040 11 00000001 00000000
13 00000001 00000000 ffffffff 00001044 12 00000001 00000000
16 00002000 00000000 fffffffc 00001048 13 00001ffc 00000000
19 00000100 ffffffff ffffff80 0000104c 14 00000080 00000000
1c 00000007 00000007 00000010 00000400 15 00000001 00000410
1d 00000007 00000007 fffffff8 00000400 16 00000000 000003f8
1e ffffffff 00000001 00000020 00000500 17 00000001 00000520
1f ffffffff 00000001 00000020 00000500 18 00000000 00000520
20 ffffffff 00000001 0000000c 00000600 19 00000000 0000060c
21 ffffffff 00000001 0000000c 00000600 1a 00000001 0000060c
22 12345678 00000000 00000100 00000800 1b 00000804 00000900
23 00001001 00000000 00000004 00000900 1c 00000904 00001004
25 ffffffff 00000000 12345000 00001000 1d 12346000 00000000
24 ffffffff 00000000 abcde000 00001050 1e abcde000 00000000
00 11111111 22222222 33333333 44444444 1f 00000000 00000000
3f 11111111 22222222 33333333 44444444 07 00000000 00000000

// File: sim.f
hw/riscv_isa_pkg.sv
hw/exec_bus_pkg.sv
hw/exec_issue.sv
hw/exec_fifo.sv
hw/exec_alu.sv
hw/exec_top.sv
tb/tb_exec.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sim.f --top-module tb_exec -o tb_exec_sim

# the run may end in $fatal, so its status is not used; the output decides
output=$(./obj_dir/tb_exec_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi

// File: tb/tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

    localparam int          NUM_VEC         = 32;
    localparam int          WORDS_PER_VEC   = 8;   // op rs1 rs2 imm pc rd result target
    localparam int          WATCHDOG_CYCLES = NUM_VEC * 20 + 100;
    localparam logic [31:0] LFSR_SEED       = 32'h140dda05;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        in_ready;
    exec_bus_pkg::exec_req_t     in_req;
    logic                        out_valid;
    logic                        out_ready;
    exec_bus_pkg::exec_result_t  out_res;

    logic [31:0]  vec_words [NUM_VEC*WORDS_PER_VEC];
    int           checked;

    exec_top dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_valid_i  (in_valid),
        .in_req_i    (in_req),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_res_o   (out_res),
        .out_ready_i (out_ready)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                               test_name, field, expected, actual));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset and vector load

    initial begin : main
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        checked   = 0;
        $readmemh("tb/exec_tests.mem", vec_words);
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // input side, holds each vector until it is taken
    initial begin : driver
        int           sent;
        int           base;
        logic         fire;
        logic [31:0]  gap_lfsr;
        logic         gap_bit;
        sent     = 0;
        gap_lfsr = LFSR_SEED;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        while (sent < NUM_VEC) begin
            if (!in_valid) begin
                gap_lfsr = lfsr_step(gap_lfsr);
                gap_bit  = gap_lfsr[0];
                gap_lfsr = lfsr_step(gap_lfsr);
                if (!(gap_bit && gap_lfsr[0])) begin   // idle about one cycle in four
                    base            = sent * WORDS_PER_VEC;
                    in_req.op       = riscv_isa_pkg::exec_op_e'(vec_words[base][5:0]);
                    in_req.rs1_data = vec_words[base+1];
                    in_req.rs2_data = vec_words[base+2];
                    in_req.imm      = vec_words[base+3];
                    in_req.pc       = vec_words[base+4];
                    in_req.rd       = vec_words[base+5][4:0];
                    in_valid        = 1'b1;
                end
            end
            @(negedge clk);
            fire = in_valid && in_ready;
            @(posedge clk);
            #1;
            if (fire) begin
                sent     = sent + 1;
                in_valid = 1'b0;
            end
        end
    end

    initial begin : back_pressure
        logic [31:0]  ready_lfsr;
        ready_lfsr = LFSR_SEED;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready  = ready_lfsr[0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side, results must match vectors in order

    initial begin : monitor
        int     base;
        string  name;
        @(posedge rst_n);
        while (checked < NUM_VEC) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                base = checked * WORDS_PER_VEC;
                name = $sformatf("vec%0d", checked);
                check_value(name, "rd", vec_words[base+5], 32'(out_res.rd));
                check_value(name, "result", vec_words[base+6], out_res.result);
                check_value(name, "target", vec_words[base+7], out_res.target);
                checked = checked + 1;
            end
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout: only %0d of %0d results arrived within %0d cycles",
                           checked, NUM_VEC, WATCHDOG_CYCLES));
    end

endmodule

// File: hw/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        in_valid_i,
    input  exec_bus_pkg::exec_req_t     in_req_i,
    output logic                        in_ready_o,

    output logic                        out_valid_o,
    output exec_bus_pkg::exec_result_t  out_res_o,
    input  logic                        out_ready_i
);

    logic                        iss_valid;
    logic                        iss_ready;
    exec_bus_pkg::exec_issued_t  iss_data;

    logic                        alu_in_valid;
    logic                        alu_in_ready;
    exec_bus_pkg::exec_issued_t  alu_in_data;

    logic                        alu_out_valid;
    logic                        alu_out_ready;
    exec_bus_pkg::exec_result_t  alu_out_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue -> fifo -> alu -> fifo

    exec_issue u_issue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_req_i    (in_req_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (iss_valid),
        .out_iss_o   (iss_data),
        .out_ready_i (iss_ready)
    );

    exec_fifo #(
        .payload_t (exec_bus_pkg::exec_issued_t),
        .DEPTH     (exec_bus_pkg::EXEC_FIFO_DEPTH)
    ) u_iss_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (iss_valid),
        .wr_ready_o (iss_ready),
        .wr_data_i  (iss_data),
        .rd_valid_o (alu_in_valid),
        .rd_ready_i (alu_in_ready),
        .rd_data_o  (alu_in_data)
    );

    exec_alu u_alu (
        .in_valid_i  (alu_in_valid),
        .in_iss_i    (alu_in_data),
        .in_ready_o  (alu_in_ready),
        .out_valid_o (alu_out_valid),
        .out_res_o   (alu_out_data),
        .out_ready_i (alu_out_ready)
    );

    exec_fifo #(
        .payload_t (exec_bus_pkg::exec_result_t),
        .DEPTH     (exec_bus_pkg::EXEC_FIFO_DEPTH)
    ) u_res_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (alu_out_valid),
        .wr_ready_o (alu_out_ready),
        .wr_data_i  (alu_out_data),
        .rd_valid_o (out_valid_o),
        .rd_ready_i (out_ready_i),
        .rd_data_o  (out_res_o)
    );

endmodule

// File: hw/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  logic                        in_valid_i,
    input  exec_bus_pkg::exec_issued_t  in_iss_i,
    output logic                        in_ready_o,

    output logic                        out_valid_o,
    output exec_bus_pkg::exec_result_t  out_res_o,
    input  logic                        out_ready_i
);

    logic [riscv_isa_pkg::XLEN-1:0]     a;
    logic [riscv_isa_pkg::XLEN-1:0]     b;
    logic [riscv_isa_pkg::SHAMT_W-1:0]  shamt;
    logic                               lt_s;
    logic                               lt_u;
    logic                               eq;
    logic [riscv_isa_pkg::XLEN-1:0]     link;
    logic [riscv_isa_pkg::XLEN-1:0]     tgt_sum;
    logic [riscv_isa_pkg::XLEN-1:0]     result;
    logic [riscv_isa_pkg::XLEN-1:0]     target;

    // no storage here, handshake passes straight through
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    assign a     = in_iss_i.op_a;
    assign b     = in_iss_i.op_b;
    assign shamt = b[riscv_isa_pkg::SHAMT_W-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared compares and adders

    assign lt_s    = ($signed(a) < $signed(b));
    assign lt_u    = (a < b);
    assign eq      = (a == b);
    assign link    = in_iss_i.pc + riscv_isa_pkg::XLEN'(4);
    assign tgt_sum = in_iss_i.tgt_base + in_iss_i.tgt_off;

    always_comb begin
        case (in_iss_i.op)
            // add group, includes load/store address and auipc
            riscv_isa_pkg::OP_ADD, riscv_isa_pkg::OP_ADDI,
            riscv_isa_pkg::OP_LB, riscv_isa_pkg::OP_LH, riscv_isa_pkg::OP_LW,
            riscv_isa_pkg::OP_LBU, riscv_isa_pkg::OP_LHU,
            riscv_isa_pkg::OP_SB, riscv_isa_pkg::OP_SH, riscv_isa_pkg::OP_SW,
            riscv_isa_pkg::OP_AUIPC:                    result = a + b;
            riscv_isa_pkg::OP_SUB:                      result = a - b;

            riscv_isa_pkg::OP_XOR, riscv_isa_pkg::OP_XORI: result = a ^ b;
            riscv_isa_pkg::OP_OR,  riscv_isa_pkg::OP_ORI:  result = a | b;
            riscv_isa_pkg::OP_AND, riscv_isa_pkg::OP_ANDI: result = a & b;

            riscv_isa_pkg::OP_SLL, riscv_isa_pkg::OP_SLLI: result = a << shamt;
            riscv_isa_pkg::OP_SRL, riscv_isa_pkg::OP_SRLI: result = a >> shamt;
            riscv_isa_pkg::OP_SRA, riscv_isa_pkg::OP_SRAI: result = $signed(a) >>> shamt;

            riscv_isa_pkg::OP_SLT,  riscv_isa_pkg::OP_SLTI,
            riscv_isa_pkg::OP_BLT:                      result = riscv_isa_pkg::XLEN'(lt_s);
            riscv_isa_pkg::OP_SLTU, riscv_isa_pkg::OP_SLTIU,
            riscv_isa_pkg::OP_BLTU:                     result = riscv_isa_pkg::XLEN'(lt_u);

            // branch taken flag
            riscv_isa_pkg::OP_BEQ:                      result = riscv_isa_pkg::XLEN'(eq);
            riscv_isa_pkg::OP_BNE:                      result = riscv_isa_pkg::XLEN'(!eq);
            riscv_isa_pkg::OP_BGE:                      result = riscv_isa_pkg::XLEN'(!lt_s);
            riscv_isa_pkg::OP_BGEU:                     result = riscv_isa_pkg::XLEN'(!lt_u);

            riscv_isa_pkg::OP_JAL, riscv_isa_pkg::OP_JALR: result = link;
            riscv_isa_pkg::OP_LUI:                      result = b;
            default:                                    result = '0;   // none or unknown
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch / jump target

    always_comb begin
        target = '0;
        if (riscv_isa_pkg::is_branch(in_iss_i.op) || riscv_isa_pkg::is_jump(in_iss_i.op)) begin
            target = tgt_sum;
            if (in_iss_i.op == riscv_isa_pkg::OP_JALR) begin
                target[0] = 1'b0;
            end
        end
    end

    assign out_res_o.rd     = in_iss_i.rd;
    assign out_res_o.result = result;
    assign out_res_o.target = target;

endmodule

// File: hw/exec_fifo.sv
`timescale 1ns/1ps

module exec_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      wr_valid_i,
    output logic      wr_ready_o,
    input  payload_t  wr_data_i,

    output logic      rd_valid_o,
    input  logic      rd_ready_i,
    output payload_t  rd_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              wr_en;
    logic              rd_en;

    assign wr_ready_o = (count_q != CNT_W'(DEPTH));   // low only while full
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem_q[rd_ptr_q];

    assign wr_en = wr_valid_i && wr_ready_o;
    assign rd_en = rd_valid_o && rd_ready_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // none, or one in and one out
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

// File: hw/exec_issue.sv
`timescale 1ns/1ps

module exec_issue (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        in_valid_i,
    input  exec_bus_pkg::exec_req_t     in_req_i,
    output logic                        in_ready_o,

    output logic                        out_valid_o,
    output exec_bus_pkg::exec_issued_t  out_iss_o,
    input  logic                        out_ready_i
);

    logic                        full_q;
    logic                        take_in;
    exec_bus_pkg::exec_issued_t  iss_d;
    exec_bus_pkg::exec_issued_t  iss_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection

    always_comb begin
        iss_d.op = in_req_i.op;
        iss_d.pc = in_req_i.pc;
        iss_d.rd = in_req_i.rd;

        if (in_req_i.op == riscv_isa_pkg::OP_AUIPC) begin
            iss_d.op_a = in_req_i.pc;
        end else begin
            iss_d.op_a = in_req_i.rs1_data;
        end

        if (riscv_isa_pkg::op_b_is_imm(in_req_i.op)) begin
            iss_d.op_b = in_req_i.imm;
        end else begin
            iss_d.op_b = in_req_i.rs2_data;   // register and branch forms
        end

        // jalr jumps relative to rs1, all others relative to pc
        if (in_req_i.op == riscv_isa_pkg::OP_JALR) begin
            iss_d.tgt_base = in_req_i.rs1_data;
        end else begin
            iss_d.tgt_base = in_req_i.pc;
        end
        iss_d.tgt_off = in_req_i.imm;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one-entry holding register

    assign in_ready_o  = !full_q || out_ready_i;   // pass-through when drained same cycle
    assign take_in     = in_valid_i && in_ready_o;
    assign out_valid_o = full_q;
    assign out_iss_o   = iss_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (take_in) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_in) begin
            iss_q <= iss_d;
        end
    end

endmodule

// File: hw/exec_bus_pkg.sv
package exec_bus_pkg;

    localparam int EXEC_FIFO_DEPTH = 2;   // same depth on both buffers

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded instruction as it enters the stage
    typedef struct packed {
        riscv_isa_pkg::exec_op_e               op;
        logic [riscv_isa_pkg::XLEN-1:0]        rs1_data;
        logic [riscv_isa_pkg::XLEN-1:0]        rs2_data;
        logic [riscv_isa_pkg::XLEN-1:0]        imm;
        logic [riscv_isa_pkg::XLEN-1:0]        pc;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rd;
    } exec_req_t;

    // operands already picked, ready for the alu
    typedef struct packed {
        riscv_isa_pkg::exec_op_e               op;
        logic [riscv_isa_pkg::XLEN-1:0]        op_a;
        logic [riscv_isa_pkg::XLEN-1:0]        op_b;
        logic [riscv_isa_pkg::XLEN-1:0]        tgt_base;   // pc, or rs1 for jalr
        logic [riscv_isa_pkg::XLEN-1:0]        tgt_off;
        logic [riscv_isa_pkg::XLEN-1:0]        pc;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rd;
    } exec_issued_t;

    typedef struct packed {
        logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rd;
        logic [riscv_isa_pkg::XLEN-1:0]        result;
        logic [riscv_isa_pkg::XLEN-1:0]        target;
    } exec_result_t;

endpackage

// File: hw/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;   // shift amount, low bits of operand b

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation codes, values are fixed so vector files can use them
    typedef enum logic [5:0] {
        OP_NONE  = 6'd0,    // also covers csr, ecall, ebreak, fence
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_XOR   = 6'd3,
        OP_OR    = 6'd4,
        OP_AND   = 6'd5,
        OP_SLL   = 6'd6,
        OP_SRL   = 6'd7,
        OP_SRA   = 6'd8,
        OP_SLT   = 6'd9,
        OP_SLTU  = 6'd10,
        OP_ADDI  = 6'd11,
        OP_XORI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_ANDI  = 6'd14,
        OP_SLLI  = 6'd15,
        OP_SRLI  = 6'd16,
        OP_SRAI  = 6'd17,
        OP_SLTI  = 6'd18,
        OP_SLTIU = 6'd19,
        OP_LB    = 6'd20,
        OP_LH    = 6'd21,
        OP_LW    = 6'd22,
        OP_LBU   = 6'd23,
        OP_LHU   = 6'd24,
        OP_SB    = 6'd25,
        OP_SH    = 6'd26,
        OP_SW    = 6'd27,
        OP_BEQ   = 6'd28,
        OP_BNE   = 6'd29,
        OP_BLT   = 6'd30,
        OP_BGE   = 6'd31,
        OP_BLTU  = 6'd32,
        OP_BGEU  = 6'd33,
        OP_JAL   = 6'd34,
        OP_JALR  = 6'd35,
        OP_LUI   = 6'd36,
        OP_AUIPC = 6'd37
    } exec_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // class helpers

    // second operand comes from the immediate
    function automatic logic op_b_is_imm(exec_op_e op);
        return op inside {OP_ADDI, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI,
                          OP_SRAI, OP_SLTI, OP_SLTIU, OP_LB, OP_LH, OP_LW,
                          OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW, OP_LUI, OP_AUIPC};
    endfunction

    function automatic logic is_branch(exec_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    function automatic logic is_jump(exec_op_e op);
        return op inside {OP_JAL, OP_JALR};
    endfunction

endpackage
